// ==== include/memory_game_settings.svh ====
// card and pair counts, start time of the countdown, clock cycles per second
`ifndef MEMORY_GAME_SETTINGS_SVH
`define MEMORY_GAME_SETTINGS_SVH

// card bank on the switch row
`define MG_CARD_COUNT 18 // one switch per card
`define MG_PAIR_COUNT 9 // fixed pairs, two cards each

// countdown start, decimal digits
`define MG_START_SECONDS_TENS 6
`define MG_START_SECONDS_ONES 0

// board clock is 50 MHz, one tick per second
`define MG_TICK_CYCLES 50000000

`endif

// ==== src/memory_game_pkg.sv ====
// shared types: card and pair masks, player, score, time, selection, display codes, FSM states
`include "memory_game_settings.svh"

package memory_game_pkg;

	typedef logic [`MG_CARD_COUNT-1:0] card_mask_t; // one bit per card switch
	typedef logic [`MG_PAIR_COUNT-1:0] pair_mask_t; // claimed record, one bit per pair

	typedef enum logic
	{
		player_one,
		player_two
	} player_t;

	typedef logic [3:0] score_t; // pairs won, at most nine
	typedef logic [3:0] bcd_digit_t; // 0 to 9 only

	typedef struct packed
	{
		bcd_digit_t tens;
		bcd_digit_t ones;
	} game_time_t;

	typedef struct packed
	{
		card_mask_t first; // card taken on the first release
		card_mask_t second; // card taken on the second release
	} selection_t;

	// 0 to 9 show the digit itself
	typedef logic [3:0] digit_code_t;
	localparam digit_code_t code_tag_p = 4'hA; // letter P
	localparam digit_code_t code_blank = 4'hB; // all segments dark

	typedef logic [6:0] seg_t; // active low, segment g is bit 6

	typedef enum logic [2:0]
	{
		choose_first,
		wait_first,
		choose_second,
		wait_second,
		check_press,
		check_wait
	} select_state_t;

endpackage

// ==== src/seg_decoder.sv ====
// digit code to active-low seven-segment pattern
`timescale 1ns/1ps

module seg_decoder
(
	input memory_game_pkg::digit_code_t code,
	output memory_game_pkg::seg_t seg
);

	always_comb
	begin
		case (code)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0011000;
			memory_game_pkg::code_tag_p: seg = 7'b0001100; // P
			memory_game_pkg::code_blank: seg = 7'b1111111;
			default: seg = 7'b1111111; // spare codes stay dark
		endcase
	end

endmodule

// ==== src/turn_control.sv ====
// button FSM for the press and release sequence, card capture registers, check strobe
`timescale 1ns/1ps

module turn_control
(
	input logic clock,
	input logic reset_n,
	input logic go, // high while the button is held
	input memory_game_pkg::card_mask_t card_select,
	output memory_game_pkg::selection_t selection,
	output logic check
);

	memory_game_pkg::select_state_t state;
	memory_game_pkg::select_state_t state_next;
	logic load_first;
	logic load_second;

	always_comb
	begin
		state_next = state;
		case (state)
			memory_game_pkg::choose_first:
				state_next = go ? memory_game_pkg::wait_first : memory_game_pkg::choose_first;
			memory_game_pkg::wait_first:
				state_next = go ? memory_game_pkg::wait_first : memory_game_pkg::choose_second;
			memory_game_pkg::choose_second:
				state_next = go ? memory_game_pkg::wait_second : memory_game_pkg::choose_second;
			memory_game_pkg::wait_second:
				state_next = go ? memory_game_pkg::wait_second : memory_game_pkg::check_press;
			memory_game_pkg::check_press:
				state_next = go ? memory_game_pkg::check_wait : memory_game_pkg::check_press;
			memory_game_pkg::check_wait:
				state_next = go ? memory_game_pkg::check_wait : memory_game_pkg::choose_first;
			default:
				state_next = memory_game_pkg::choose_first; // unused codes recover
		endcase
	end

	// release edges
	assign load_first = (state == memory_game_pkg::wait_first) && !go;
	assign load_second = (state == memory_game_pkg::wait_second) && !go;
	assign check = (state == memory_game_pkg::check_wait) && !go; // one cycle, back to start

	always_ff @(posedge clock)
	begin
		if (!reset_n)
			state <= memory_game_pkg::choose_first;
		else
			state <= state_next;
	end

	// switch bank sampled on the release
	always_ff @(posedge clock)
	begin
		if (load_first)
			selection.first <= card_select;
		if (load_second)
			selection.second <= card_select;
	end

endmodule

// ==== src/pair_judge.sv ====
// pair table, claimed pairs, both score counters, turn owner, game-over decision
`timescale 1ns/1ps
`include "memory_game_settings.svh"

module pair_judge
(
	input logic clock,
	input logic reset_n,
	input memory_game_pkg::selection_t selection,
	input logic check, // one cycle per completed turn
	input logic time_up,
	output memory_game_pkg::score_t score_one,
	output memory_game_pkg::score_t score_two,
	output memory_game_pkg::player_t turn,
	output logic game_over
);

	// card numbers of each pair, high card first
	localparam int pair_high [`MG_PAIR_COUNT] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};
	localparam int pair_low [`MG_PAIR_COUNT] = '{10, 0, 4, 3, 2, 11, 7, 5, 1};

	memory_game_pkg::pair_mask_t claimed;
	memory_game_pkg::pair_mask_t pair_hits; // pairs matching the two cards
	logic both_one_hot;
	logic hit;

	always_comb
	begin
		pair_hits = '0;
		for (int p = 0; p < `MG_PAIR_COUNT; p++)
		begin
			// either order counts
			pair_hits[p] =
				(selection.first[pair_high[p]] && selection.second[pair_low[p]]) ||
				(selection.second[pair_high[p]] && selection.first[pair_low[p]]);
		end
	end

	assign both_one_hot = $onehot(selection.first) && $onehot(selection.second);
	assign hit = both_one_hot && |(pair_hits & ~claimed); // already claimed is a miss

	assign game_over = time_up || (&claimed);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			claimed <= '0;
			score_one <= '0;
			score_two <= '0;
			turn <= memory_game_pkg::player_one;
		end
		else if (check && !game_over) // frozen once the game ends
		begin
			if (hit)
			begin
				claimed <= claimed | pair_hits;
				if (turn == memory_game_pkg::player_one)
					score_one <= score_one + 1'b1;
				else
					score_two <= score_two + 1'b1; // hit keeps the turn
			end
			else
			begin
				// miss hands over
				turn <= (turn == memory_game_pkg::player_one) ?
					memory_game_pkg::player_two : memory_game_pkg::player_one;
			end
		end
	end

endmodule

// ==== src/game_clock.sv ====
// one-second rate divider and two-digit decimal countdown with the time-up flag
`timescale 1ns/1ps
`include "memory_game_settings.svh"

module game_clock
#(
	parameter int tick_cycles = `MG_TICK_CYCLES
)
(
	input logic clock,
	input logic reset_n,
	input logic game_over,
	output logic tick, // one cycle per second
	output memory_game_pkg::game_time_t time_left,
	output logic time_up
);

	localparam int count_width = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
	localparam logic [count_width-1:0] count_reload = count_width'(tick_cycles - 1);

	logic [count_width-1:0] tick_count;

	// down-counter, reloads on its own tick
	always_ff @(posedge clock)
	begin
		if (!reset_n)
			tick_count <= count_reload;
		else if (tick)
			tick_count <= count_reload;
		else
			tick_count <= tick_count - 1'b1;
	end

	assign tick = (tick_count == '0);

	assign time_up = (time_left.tens == '0) && (time_left.ones == '0);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			time_left.tens <= memory_game_pkg::bcd_digit_t'(`MG_START_SECONDS_TENS);
			time_left.ones <= memory_game_pkg::bcd_digit_t'(`MG_START_SECONDS_ONES);
		end
		else if (tick && !time_up && !game_over) // hold at 00 and after the end
		begin
			if (time_left.ones == '0)
			begin
				time_left.ones <= 4'd9; // borrow from tens
				time_left.tens <= time_left.tens - 1'b1;
			end
			else
				time_left.ones <= time_left.ones - 1'b1;
		end
	end

endmodule

// ==== src/score_display.sv ====
// leader digit, end-of-game flash phase, six seven-segment digit decoders
`timescale 1ns/1ps

module score_display
(
	input logic clock,
	input logic reset_n,
	input logic tick,
	input logic game_over,
	input memory_game_pkg::score_t score_one,
	input memory_game_pkg::score_t score_two,
	input memory_game_pkg::game_time_t time_left,
	output memory_game_pkg::seg_t hex_score_one,
	output memory_game_pkg::seg_t hex_score_two,
	output memory_game_pkg::seg_t hex_time_ones,
	output memory_game_pkg::seg_t hex_time_tens,
	output memory_game_pkg::seg_t hex_tag,
	output memory_game_pkg::seg_t hex_leader
);

	memory_game_pkg::digit_code_t leader;
	memory_game_pkg::digit_code_t tag_code;
	memory_game_pkg::digit_code_t leader_code;
	logic flash_hidden; // 0 means shown

	always_comb
	begin
		if (score_one > score_two)
			leader = 4'd1;
		else if (score_two > score_one)
			leader = 4'd2;
		else
			leader = 4'd0; // tie
	end

	// blinks only after the game ends
	always_ff @(posedge clock)
	begin
		if (!reset_n)
			flash_hidden <= 1'b0;
		else if (tick && game_over)
			flash_hidden <= !flash_hidden;
	end

	assign tag_code = flash_hidden ? memory_game_pkg::code_blank : memory_game_pkg::code_tag_p;
	assign leader_code = flash_hidden ? memory_game_pkg::code_blank : leader;

	// scores and time never blink
	seg_decoder u_score_one (.code(score_one), .seg(hex_score_one));
	seg_decoder u_score_two (.code(score_two), .seg(hex_score_two));
	seg_decoder u_time_ones (.code(time_left.ones), .seg(hex_time_ones));
	seg_decoder u_time_tens (.code(time_left.tens), .seg(hex_time_tens));
	seg_decoder u_tag (.code(tag_code), .seg(hex_tag));
	seg_decoder u_leader (.code(leader_code), .seg(hex_leader));

endmodule

// ==== src/memory_game.sv ====
// top level of the memory card game: selection FSM, pair judge, game clock, display
`timescale 1ns/1ps
`include "memory_game_settings.svh"

module memory_game
#(
	parameter int tick_cycles = `MG_TICK_CYCLES // cycles per second
)
(
	input logic clock,
	input logic reset_n,
	input logic go, // select button, high when pressed
	input memory_game_pkg::card_mask_t card_select,
	output memory_game_pkg::player_t turn,
	output logic game_over,
	output memory_game_pkg::seg_t hex_score_one,
	output memory_game_pkg::seg_t hex_score_two,
	output memory_game_pkg::seg_t hex_time_ones,
	output memory_game_pkg::seg_t hex_time_tens,
	output memory_game_pkg::seg_t hex_tag,
	output memory_game_pkg::seg_t hex_leader
);

	memory_game_pkg::selection_t selection;
	logic check;
	memory_game_pkg::score_t score_one;
	memory_game_pkg::score_t score_two;
	memory_game_pkg::game_time_t time_left;
	logic time_up;
	logic tick;

	turn_control u_turn_control (.clock, .reset_n, .go, .card_select, .selection, .check);

	pair_judge u_pair_judge (
		.clock, .reset_n, .selection, .check, .time_up,
		.score_one, .score_two, .turn, .game_over
	);

	game_clock #(.tick_cycles(tick_cycles)) u_game_clock (
		.clock, .reset_n, .game_over, .tick, .time_left, .time_up
	);

	score_display u_score_display (
		.clock, .reset_n, .tick, .game_over, .score_one, .score_two, .time_left,
		.hex_score_one, .hex_score_two, .hex_time_ones, .hex_time_tens, .hex_tag, .hex_leader
	);

endmodule

// ==== tests/memory_game_assertions.sv ====
// concurrent checks on game-over hold, turn changes and time digit range, bound to the top level
`timescale 1ns/1ps

module memory_game_assertions
(
	input logic clock,
	input logic reset_n,
	input logic check, // judge strobe inside the top level
	input logic game_over,
	input memory_game_pkg::player_t turn,
	input memory_game_pkg::game_time_t time_left
);

	int failures = 0; // failed assertion count

	// once over, only reset clears it
	game_over_holds: assert property (@(posedge clock) disable iff (!reset_n)
		game_over |=> game_over)
		else
		begin
			failures++;
			$error("game_over fell without a reset");
		end

	turn_moves_on_check: assert property (@(posedge clock) disable iff (!reset_n)
		(turn != $past(turn)) |-> $past(check))
		else
		begin
			failures++;
			$error("turn changed without a check strobe");
		end

	time_digits_decimal: assert property (@(posedge clock) disable iff (!reset_n)
		(time_left.tens <= 4'd9) && (time_left.ones <= 4'd9))
		else
		begin
			failures++;
			$error("time digit above 9");
		end

endmodule

bind memory_game memory_game_assertions u_assertions
(
	.clock, .reset_n, .check, .game_over, .turn, .time_left
);

// ==== tests/memory_game_tb.sv ====
// testbench for the memory game: clock, reset, random turns, reference model, compare tasks, watchdog
`timescale 1ns/1ps
`include "memory_game_settings.svh"

module memory_game_tb;

	localparam int tick_len = 16; // cycles per game second
	localparam int reset_cycles = 10;
	localparam int turn_max = 24; // three presses plus releases, 4 cycles each at most
	localparam int random_turns = 16;
	localparam int pair_replays = 2; // pair 0 reversed, then chosen again once claimed
	localparam int late_turns = 3; // played after game over
	localparam int flash_ticks = 4;
	localparam int planned_turns = random_turns + pair_replays + `MG_PAIR_COUNT
		+ 2 * late_turns;
	localparam int watchdog_cycles = planned_turns * turn_max
		+ 2 * (61 + flash_ticks) * tick_len + 2 * reset_cycles + 500;
	localparam int code_p = 10; // index of P in the table
	localparam int code_off = 11; // blank digit

	// active low, g is the top bit
	localparam memory_game_pkg::seg_t seg_table [12] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010,
		7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000, 7'b0001100, 7'b1111111};
	localparam int pair_a [`MG_PAIR_COUNT] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};
	localparam int pair_b [`MG_PAIR_COUNT] = '{10, 0, 4, 3, 2, 11, 7, 5, 1};

	logic clock;
	logic reset_n;
	logic go;
	memory_game_pkg::card_mask_t card_select;
	memory_game_pkg::player_t turn;
	logic game_over;
	memory_game_pkg::seg_t hex_score_one;
	memory_game_pkg::seg_t hex_score_two;
	memory_game_pkg::seg_t hex_time_ones;
	memory_game_pkg::seg_t hex_time_tens;
	memory_game_pkg::seg_t hex_tag;
	memory_game_pkg::seg_t hex_leader;

	int unsigned lcg_state = 83786;
	memory_game_pkg::card_mask_t sent_first; // cards of the turn in progress
	memory_game_pkg::card_mask_t sent_second;
	int checks_sent = 0; // completed turns handed to the model

	// reference model state
	memory_game_pkg::pair_mask_t m_claimed;
	memory_game_pkg::score_t m_score_one;
	memory_game_pkg::score_t m_score_two;
	memory_game_pkg::player_t m_turn;
	int m_tens;
	int m_ones;
	int m_cycles; // since end of reset
	int checks_seen;
	bit m_hidden; // flash phase

	memory_game #(.tick_cycles(tick_len)) DUT (
		.clock, .reset_n, .go, .card_select, .turn, .game_over,
		.hex_score_one, .hex_score_two, .hex_time_ones, .hex_time_tens, .hex_tag, .hex_leader
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	function automatic int unsigned rand_below(int unsigned n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 8) % n; // low bits are weak
	endfunction

	function automatic memory_game_pkg::card_mask_t random_mask();
		return memory_game_pkg::card_mask_t'(rand_below(1 << `MG_CARD_COUNT));
	endfunction

	function automatic memory_game_pkg::card_mask_t one_hot(int card);
		return memory_game_pkg::card_mask_t'(1) << card;
	endfunction

	function automatic bit model_over();
		return ((m_tens == 0) && (m_ones == 0)) || (m_claimed == '1);
	endfunction

	// -1 unless exactly one switch is on
	function automatic int card_index(memory_game_pkg::card_mask_t mask);
		int idx;
		idx = -1;
		if ($countones(mask) == 1)
			for (int c = 0; c < `MG_CARD_COUNT; c++)
				if (mask[c])
					idx = c;
		return idx;
	endfunction

	task automatic judge_model(memory_game_pkg::card_mask_t first,
		memory_game_pkg::card_mask_t second);
		int a;
		int b;
		int hit_pair;
		a = card_index(first);
		b = card_index(second);
		hit_pair = -1;
		for (int p = 0; p < `MG_PAIR_COUNT; p++)
			if (a >= 0 && b >= 0 && !m_claimed[p] &&
				((a == pair_a[p] && b == pair_b[p]) || (a == pair_b[p] && b == pair_a[p])))
				hit_pair = p;
		if (hit_pair >= 0)
		begin
			m_claimed[hit_pair] = 1'b1;
			if (m_turn == memory_game_pkg::player_one)
				m_score_one++; // hitter keeps the turn
			else
				m_score_two++;
		end
		else
			m_turn = (m_turn == memory_game_pkg::player_one) ?
				memory_game_pkg::player_two : memory_game_pkg::player_one;
	endtask

	always @(posedge clock)
	begin
		bit ended;
		ended = model_over(); // state before this edge
		if (!reset_n)
		begin
			m_claimed = '0;
			m_score_one = '0;
			m_score_two = '0;
			m_turn = memory_game_pkg::player_one;
			m_tens = `MG_START_SECONDS_TENS;
			m_ones = `MG_START_SECONDS_ONES;
			m_cycles = 0;
			m_hidden = 1'b0;
			checks_seen = checks_sent;
		end
		else
		begin
			m_cycles++;
			if (checks_seen != checks_sent)
			begin
				if (!ended)
					judge_model(sent_first, sent_second); // late checks ignored
				checks_seen = checks_sent;
			end
			if (m_cycles % tick_len == 0)
			begin
				if (ended)
					m_hidden = !m_hidden;
				else if (m_ones == 0)
				begin
					m_ones = 9; // borrow
					m_tens--;
				end
				else
					m_ones--;
			end
		end
	end

	task automatic end_with_failure();
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_seg(string name, memory_game_pkg::seg_t expected,
		memory_game_pkg::seg_t actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic check_player(string name, memory_game_pkg::player_t expected,
		memory_game_pkg::player_t actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %s, got %s", $time, name,
				expected.name(), actual.name());
			end_with_failure();
		end
	endtask

	task automatic check_level(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			end_with_failure();
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clock)
	begin
		int lead;
		if (reset_n)
		begin
			lead = 0; // tie
			if (m_score_one > m_score_two)
				lead = 1;
			else if (m_score_two > m_score_one)
				lead = 2;
			check_player("turn", m_turn, turn);
			check_level("game_over", model_over(), game_over);
			check_seg("hex_score_one", seg_table[m_score_one], hex_score_one);
			check_seg("hex_score_two", seg_table[m_score_two], hex_score_two);
			check_seg("hex_time_ones", seg_table[m_ones], hex_time_ones);
			check_seg("hex_time_tens", seg_table[m_tens], hex_time_tens);
			check_seg("hex_tag", seg_table[m_hidden ? code_off : code_p], hex_tag);
			check_seg("hex_leader", seg_table[m_hidden ? code_off : lead], hex_leader);
			if (DUT.u_assertions.failures != 0)
			begin
				$display("a concurrent assertion on the DUT failed at %0t ns", $time);
				end_with_failure();
			end
		end
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the game sequence did not finish within %0d cycles", watchdog_cycles);
		end_with_failure();
	end

	task automatic step();
		@(posedge clock);
		#2; // drive after the edge
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		go = 1'b0;
		card_select = '0;
		repeat (reset_cycles) step();
		reset_n = 1'b1;
	endtask

	// one press, then a release carrying the card
	task automatic press_release(memory_game_pkg::card_mask_t card, bit last);
		int hold;
		int rest;
		hold = 1 + rand_below(4);
		rest = 1 + rand_below(4);
		go = 1'b1;
		card_select = random_mask(); // noise while held
		repeat (hold) step();
		go = 1'b0;
		card_select = card;
		if (last)
			checks_sent++; // judge fires on this release
		step();
		card_select = random_mask();
		repeat (rest - 1) step();
	endtask

	task automatic play_turn(memory_game_pkg::card_mask_t first,
		memory_game_pkg::card_mask_t second);
		sent_first = first;
		sent_second = second;
		press_release(first, 1'b0);
		press_release(second, 1'b0);
		press_release(random_mask(), 1'b1);
	endtask

	task automatic random_turn(bit allow_pairs);
		int kind;
		int p;
		memory_game_pkg::card_mask_t first;
		memory_game_pkg::card_mask_t second;
		kind = rand_below(8);
		p = rand_below(`MG_PAIR_COUNT);
		first = one_hot(rand_below(`MG_CARD_COUNT));
		second = one_hot(rand_below(`MG_CARD_COUNT));
		if (allow_pairs && kind >= 6)
		begin
			first = one_hot((kind == 6) ? pair_a[p] : pair_b[p]); // both orders
			second = one_hot((kind == 6) ? pair_b[p] : pair_a[p]);
		end
		else if (kind == 5)
			second = second | random_mask(); // mostly several bits
		else if (kind == 4)
			first = '0;
		play_turn(first, second);
	endtask

	initial
	begin
		reset_n = 1'b0;
		go = 1'b0;
		card_select = '0;
		apply_reset();
		// game one ends by claiming every pair
		repeat (random_turns) random_turn(1'b1);
		// pair 0 low card first, then the same pair once it is taken
		play_turn(one_hot(pair_b[0]), one_hot(pair_a[0]));
		play_turn(one_hot(pair_a[0]), one_hot(pair_b[0]));
		for (int p = 0; p < `MG_PAIR_COUNT; p++)
			if (!m_claimed[p])
				play_turn(one_hot(pair_a[p]), one_hot(pair_b[p]));
		if (m_claimed != '1)
		begin
			$display("the first game ran out of time before every pair was claimed");
			end_with_failure();
		end
		repeat (late_turns) random_turn(1'b1);
		repeat (flash_ticks * tick_len) step();
		// game two runs out of time
		apply_reset();
		while (!model_over())
			random_turn(1'b0);
		if (m_tens != 0 || m_ones != 0)
		begin
			$display("the second game ended before the countdown reached 00");
			end_with_failure();
		end
		repeat (late_turns) random_turn(1'b1);
		repeat (flash_ticks * tick_len) step();
		if (DUT.u_assertions.failures == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("concurrent assertions on the DUT failed");
			end_with_failure();
		end
	end

endmodule

// ==== memory_game.f ====
+incdir+include
src/memory_game_pkg.sv
src/seg_decoder.sv
src/turn_control.sv
src/pair_judge.sv
src/game_clock.sv
src/score_display.sv
src/memory_game.sv
tests/memory_game_assertions.sv
tests/memory_game_tb.sv
